// File: Makefile
VERILATOR ?= verilator
TOP       ?= rob_tb
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard hdl/*.sv sim/*.sv sim/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
+incdir+sim
hdl/rob_pkg.sv
hdl/fetch_sequencer.sv
hdl/rob_storage.sv
hdl/commit_unit.sv
hdl/rob_top.sv
sim/rob_tb.sv

// File: hdl/commit_unit.sv
`timescale 1ns/1ps

module commit_unit (
  input  logic                clk,
  input  logic                rst,
  input  logic                head_valid,
  input  rob_pkg::op_class_e  head_op,
  input  rob_pkg::reg_idx_t   head_rd,
  input  rob_pkg::func3_t     head_func3,
  input  rob_pkg::word_t      head_imm,
  input  rob_pkg::addr_t      head_pc,
  input  rob_pkg::word_t      head_result,
  input  rob_pkg::addr_t      head_tar_addr,
  input  logic                store_ack,
  output logic                pop,
  output logic                commit_valid,
  output rob_pkg::reg_idx_t   commit_rd,
  output rob_pkg::word_t      commit_value,
  output logic                store_req,
  output rob_pkg::addr_t      store_addr,
  output rob_pkg::word_t      store_data,
  output rob_pkg::mem_len_t   store_len,
  output logic                flush,
  output rob_pkg::addr_t      flush_pc
);

  typedef enum logic {
    S_IDLE,
    S_STORING
  } commit_state_e;

  commit_state_e     state;
  logic              is_store;
  logic              mispredict;
  logic              is_jalr;
  logic              writes_rd;
  rob_pkg::mem_len_t len_code;

  // no retirement during the flush cycle or while a store is pending
  assign pop = (state == S_IDLE) && head_valid && !flush;

  assign is_store   = head_op == rob_pkg::OP_STORE;
  assign is_jalr    = head_op == rob_pkg::OP_JALR;
  // taken prediction was wrong
  assign mispredict = (head_op == rob_pkg::OP_BRANCH) && (head_result == '0);
  assign writes_rd  = !is_store && (head_op != rob_pkg::OP_BRANCH) && (head_rd != '0);

  always_comb begin
    case (head_func3[1:0])
      2'd0:    len_code = rob_pkg::LEN_BYTE;
      2'd1:    len_code = rob_pkg::LEN_HALF;
      default: len_code = rob_pkg::LEN_WORD;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= S_IDLE;
      commit_valid <= 1'b0;
      store_req    <= 1'b0;
      flush        <= 1'b0;
    end else begin
      commit_valid <= 1'b0;
      store_req    <= 1'b0;
      flush        <= 1'b0;
      if (state == S_STORING && store_ack) begin
        state <= S_IDLE;
      end
      if (pop) begin
        commit_valid <= writes_rd;
        store_req    <= is_store;
        flush        <= mispredict || is_jalr;
        if (is_store) begin
          state <= S_STORING;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      commit_rd    <= head_rd;
      commit_value <= head_result;
      store_addr   <= head_tar_addr;
      store_data   <= head_result;
      store_len    <= len_code;
      flush_pc     <= is_jalr ? head_tar_addr : head_pc + 32'd4;
    end
  end

  a_ack_in_storing: assert property (
    @(posedge clk) disable iff (rst) store_ack |-> state == S_STORING
  ) else $error("store_ack without a pending store");

endmodule

// File: hdl/fetch_sequencer.sv
`timescale 1ns/1ps

module fetch_sequencer #(
  parameter int IDX_W = 3
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                fetch_valid,
  input  rob_pkg::addr_t      fetch_pc,
  input  rob_pkg::word_t      fetch_instr,
  input  logic                decode_valid,
  input  rob_pkg::op_class_e  decode_op,
  input  rob_pkg::reg_idx_t   decode_rd,
  input  rob_pkg::func3_t     decode_func3,
  input  rob_pkg::word_t      decode_imm,
  input  logic [IDX_W:0]      count,
  input  logic                flush,
  output logic                fetch_req,
  output logic                decode_req,
  output rob_pkg::word_t      decode_instr,
  output logic                redirect_valid,
  output rob_pkg::addr_t      redirect_pc,
  output logic                enq_valid,
  output rob_pkg::op_class_e  enq_op,
  output rob_pkg::reg_idx_t   enq_rd,
  output rob_pkg::func3_t     enq_func3,
  output rob_pkg::word_t      enq_imm,
  output rob_pkg::addr_t      enq_pc
);

  // depth - 1, keeps one slot free for the entry in flight
  localparam logic [IDX_W:0] LAST_FREE = {1'b0, {IDX_W{1'b1}}};

  typedef enum logic [1:0] {
    S_IDLE,
    S_FETCHING,
    S_DECODING
  } seq_state_e;

  seq_state_e     state;
  rob_pkg::addr_t cur_pc;
  logic           take_imm;

  assign enq_valid = (state == S_DECODING) && decode_valid && !flush;
  assign enq_op    = decode_op;
  assign enq_rd    = decode_rd;
  assign enq_func3 = decode_func3;
  assign enq_imm   = decode_imm;
  assign enq_pc    = cur_pc;

  // branches are statically predicted taken
  assign take_imm = (decode_op == rob_pkg::OP_JAL) || (decode_op == rob_pkg::OP_BRANCH);

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= S_IDLE;
      fetch_req      <= 1'b0;
      decode_req     <= 1'b0;
      redirect_valid <= 1'b0;
    end else begin
      fetch_req      <= 1'b0;
      decode_req     <= 1'b0;
      redirect_valid <= 1'b0;
      if (flush) begin
        state <= S_IDLE;
      end else begin
        case (state)
          S_IDLE: begin
            if (count < LAST_FREE) begin
              fetch_req <= 1'b1;
              state     <= S_FETCHING;
            end
          end
          S_FETCHING: begin
            if (fetch_valid) begin
              decode_req <= 1'b1;
              state      <= S_DECODING;
            end
          end
          S_DECODING: begin
            if (decode_valid) begin
              redirect_valid <= 1'b1;
              state          <= S_IDLE;
            end
          end
          default: state <= S_IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_FETCHING && fetch_valid) begin
      cur_pc       <= fetch_pc;
      decode_instr <= fetch_instr;
    end
    if (enq_valid) begin
      redirect_pc <= cur_pc + (take_imm ? decode_imm : 32'd4);
    end
  end

  a_decode_in_state: assert property (
    @(posedge clk) disable iff (rst) decode_valid |-> state == S_DECODING
  ) else $error("decode_valid outside of decoding");

endmodule

// File: hdl/rob_pkg.sv
package rob_pkg;

  // instruction or data address
  typedef logic [31:0] addr_t;

  // instruction word, immediate or result value
  typedef logic [31:0] word_t;

  // architectural register number
  typedef logic [4:0] reg_idx_t;

  // raw func3 field from the decoder
  typedef logic [2:0] func3_t;

  // store size code sent to the memory port
  typedef logic [1:0] mem_len_t;

  localparam mem_len_t LEN_BYTE = 2'd0;
  localparam mem_len_t LEN_HALF = 2'd1;
  localparam mem_len_t LEN_WORD = 2'd3;

  // decoded instruction class
  typedef enum logic [2:0] {
    OP_ALU,
    OP_LOAD,
    OP_STORE,
    OP_BRANCH,
    OP_JAL,
    OP_JALR
  } op_class_e;

  // 8 entries by default
  localparam int DEFAULT_IDX_W = 3;

endpackage

// File: hdl/rob_storage.sv
`timescale 1ns/1ps

module rob_storage #(
  parameter int IDX_W = 3
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                flush,
  input  logic                enq_valid,
  input  rob_pkg::op_class_e  enq_op,
  input  rob_pkg::reg_idx_t   enq_rd,
  input  rob_pkg::func3_t     enq_func3,
  input  rob_pkg::word_t      enq_imm,
  input  rob_pkg::addr_t      enq_pc,
  input  logic                wb_valid,
  input  logic [IDX_W-1:0]    wb_idx,
  input  rob_pkg::word_t      wb_result,
  input  rob_pkg::addr_t      wb_tar_addr,
  input  logic                pop,
  output logic [IDX_W:0]      count,
  output logic                head_valid,
  output rob_pkg::op_class_e  head_op,
  output rob_pkg::reg_idx_t   head_rd,
  output rob_pkg::func3_t     head_func3,
  output rob_pkg::word_t      head_imm,
  output rob_pkg::addr_t      head_pc,
  output rob_pkg::word_t      head_result,
  output rob_pkg::addr_t      head_tar_addr
);

  localparam int DEPTH = 1 << IDX_W;
  localparam logic [IDX_W:0] FULL_CNT = {1'b1, {IDX_W{1'b0}}};

  logic               ready_q  [DEPTH];
  rob_pkg::op_class_e op_q     [DEPTH];
  rob_pkg::reg_idx_t  rd_q     [DEPTH];
  rob_pkg::func3_t    func3_q  [DEPTH];
  rob_pkg::word_t     imm_q    [DEPTH];
  rob_pkg::addr_t     pc_q     [DEPTH];
  rob_pkg::word_t     result_q [DEPTH];
  rob_pkg::addr_t     tar_q    [DEPTH];

  // extra top bit tells full from empty
  logic [IDX_W:0]   head_ptr;
  logic [IDX_W:0]   tail_ptr;
  logic [IDX_W-1:0] head_idx;
  logic [IDX_W-1:0] tail_idx;
  logic [IDX_W-1:0] wb_off;

  assign head_idx = head_ptr[IDX_W-1:0];
  assign tail_idx = tail_ptr[IDX_W-1:0];
  assign count    = tail_ptr - head_ptr;
  assign wb_off   = wb_idx - head_idx;

  assign head_valid    = (count != '0) && ready_q[head_idx];
  assign head_op       = op_q[head_idx];
  assign head_rd       = rd_q[head_idx];
  assign head_func3    = func3_q[head_idx];
  assign head_imm      = imm_q[head_idx];
  assign head_pc       = pc_q[head_idx];
  assign head_result   = result_q[head_idx];
  assign head_tar_addr = tar_q[head_idx];

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      head_ptr <= '0;
      tail_ptr <= '0;
    end else begin
      if (enq_valid) begin
        tail_ptr <= tail_ptr + 1'b1;
      end
      if (pop) begin
        head_ptr <= head_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (enq_valid) begin
      ready_q[tail_idx] <= 1'b0;
      op_q[tail_idx]    <= enq_op;
      rd_q[tail_idx]    <= enq_rd;
      func3_q[tail_idx] <= enq_func3;
      imm_q[tail_idx]   <= enq_imm;
      pc_q[tail_idx]    <= enq_pc;
    end
    // write-back merge, entry becomes retirable
    if (wb_valid) begin
      ready_q[wb_idx]  <= 1'b1;
      result_q[wb_idx] <= wb_result;
      tar_q[wb_idx]    <= wb_tar_addr;
    end
  end

  a_no_enq_full: assert property (
    @(posedge clk) disable iff (rst) enq_valid |-> count != FULL_CNT
  ) else $error("enqueue into a full queue");

  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (rst) pop |-> count != '0
  ) else $error("pop from an empty queue");

  a_wb_occupied: assert property (
    @(posedge clk) disable iff (rst) wb_valid |-> {1'b0, wb_off} < count
  ) else $error("write-back to an unoccupied entry");

endmodule

// File: hdl/rob_top.sv
`timescale 1ns/1ps

module rob_top #(
  parameter int IDX_W = rob_pkg::DEFAULT_IDX_W
) (
  input  logic                clk,
  input  logic                rst,
  output logic                fetch_req,
  input  logic                fetch_valid,
  input  rob_pkg::addr_t      fetch_pc,
  input  rob_pkg::word_t      fetch_instr,
  output logic                decode_req,
  output rob_pkg::word_t      decode_instr,
  input  logic                decode_valid,
  input  rob_pkg::op_class_e  decode_op,
  input  rob_pkg::reg_idx_t   decode_rd,
  input  rob_pkg::func3_t     decode_func3,
  input  rob_pkg::word_t      decode_imm,
  output logic                redirect_valid,
  output rob_pkg::addr_t      redirect_pc,
  input  logic                wb_valid,
  input  logic [IDX_W-1:0]    wb_idx,
  input  rob_pkg::word_t      wb_result,
  input  rob_pkg::addr_t      wb_tar_addr,
  output logic                commit_valid,
  output rob_pkg::reg_idx_t   commit_rd,
  output rob_pkg::word_t      commit_value,
  output logic                store_req,
  output rob_pkg::addr_t      store_addr,
  output rob_pkg::word_t      store_data,
  output rob_pkg::mem_len_t   store_len,
  input  logic                store_ack,
  output logic                flush,
  output rob_pkg::addr_t      flush_pc
);

  logic               enq_valid;
  rob_pkg::op_class_e enq_op;
  rob_pkg::reg_idx_t  enq_rd;
  rob_pkg::func3_t    enq_func3;
  rob_pkg::word_t     enq_imm;
  rob_pkg::addr_t     enq_pc;
  logic [IDX_W:0]     count;
  logic               pop;
  logic               head_valid;
  rob_pkg::op_class_e head_op;
  rob_pkg::reg_idx_t  head_rd;
  rob_pkg::func3_t    head_func3;
  rob_pkg::word_t     head_imm;
  rob_pkg::addr_t     head_pc;
  rob_pkg::word_t     head_result;
  rob_pkg::addr_t     head_tar_addr;

  fetch_sequencer #(.IDX_W(IDX_W)) u_seq (
    .clk, .rst, .fetch_valid, .fetch_pc, .fetch_instr,
    .decode_valid, .decode_op, .decode_rd, .decode_func3, .decode_imm,
    .count, .flush, .fetch_req, .decode_req, .decode_instr,
    .redirect_valid, .redirect_pc,
    .enq_valid, .enq_op, .enq_rd, .enq_func3, .enq_imm, .enq_pc
  );

  rob_storage #(.IDX_W(IDX_W)) u_storage (
    .clk, .rst, .flush,
    .enq_valid, .enq_op, .enq_rd, .enq_func3, .enq_imm, .enq_pc,
    .wb_valid, .wb_idx, .wb_result, .wb_tar_addr, .pop, .count,
    .head_valid, .head_op, .head_rd, .head_func3, .head_imm,
    .head_pc, .head_result, .head_tar_addr
  );

  commit_unit u_commit (
    .clk, .rst, .head_valid, .head_op, .head_rd, .head_func3, .head_imm,
    .head_pc, .head_result, .head_tar_addr, .store_ack, .pop,
    .commit_valid, .commit_rd, .commit_value,
    .store_req, .store_addr, .store_data, .store_len, .flush, .flush_pc
  );

endmodule

// File: sim/rob_tb_program.svh
// program table, indexed by pc[5:2]
// columns: class, rd, func3, imm, write-back result, write-back target
rob_pkg::op_class_e prog_op     [16];
rob_pkg::reg_idx_t  prog_rd     [16];
rob_pkg::func3_t    prog_func3  [16];
rob_pkg::word_t     prog_imm    [16];
rob_pkg::word_t     prog_result [16];
rob_pkg::addr_t     prog_tar    [16];

task automatic set_entry(input int i, input rob_pkg::op_class_e op, input int rd,
                         input int f3, input rob_pkg::word_t imm,
                         input rob_pkg::word_t res, input rob_pkg::addr_t tar);
  prog_op[i]     = op;
  prog_rd[i]     = rob_pkg::reg_idx_t'(rd);
  prog_func3[i]  = rob_pkg::func3_t'(f3);
  prog_imm[i]    = imm;
  prog_result[i] = res;
  prog_tar[i]    = tar;
endtask

task automatic load_program;
  set_entry(0,  rob_pkg::OP_ALU,    1, 0, 32'd0,        32'h11,        32'h0);
  set_entry(1,  rob_pkg::OP_LOAD,   2, 2, 32'd0,        32'h22,        32'h80);
  // rd zero, never commits
  set_entry(2,  rob_pkg::OP_ALU,    0, 0, 32'd0,        32'h33,        32'h0);
  set_entry(3,  rob_pkg::OP_STORE,  0, 0, 32'd0,        32'hab,        32'h100);
  set_entry(4,  rob_pkg::OP_STORE,  0, 1, 32'd0,        32'hbeef,      32'h104);
  // taken branch to 28
  set_entry(5,  rob_pkg::OP_BRANCH, 0, 0, 32'd8,        32'h1,         32'h0);
  set_entry(6,  rob_pkg::OP_ALU,    3, 0, 32'd0,        32'h3,         32'h0);
  // not taken, wrong path at 40
  set_entry(7,  rob_pkg::OP_BRANCH, 0, 1, 32'd12,       32'h0,         32'h0);
  set_entry(8,  rob_pkg::OP_STORE,  0, 2, 32'd0,        32'hdeadbeef,  32'h200);
  set_entry(9,  rob_pkg::OP_JAL,    4, 0, 32'd8,        32'd40,        32'h0);
  set_entry(10, rob_pkg::OP_ALU,    7, 0, 32'd0,        32'h77,        32'h0);
  set_entry(11, rob_pkg::OP_JALR,   5, 0, 32'd0,        32'd48,        32'd52);
  set_entry(12, rob_pkg::OP_ALU,    9, 0, 32'd0,        32'h99,        32'h0);
  set_entry(13, rob_pkg::OP_JAL,    0, 0, 32'd4,        32'd56,        32'h0);
  // loop body at 56 and 60
  set_entry(14, rob_pkg::OP_ALU,    6, 0, 32'd0,        32'h66,        32'h0);
  set_entry(15, rob_pkg::OP_JAL,    1, 0, 32'hfffffffc, 32'd64,        32'h0);
endtask

// File: sim/rob_tb.sv
`timescale 1ns/1ps

module rob_tb;

  localparam int IDX_W     = rob_pkg::DEFAULT_IDX_W;
  localparam int DEPTH     = 1 << IDX_W;
  localparam int N_RETIRE  = 40;
  localparam int TIMEOUT   = 40 * N_RETIRE;
  localparam int FILL_AT   = N_RETIRE / 2;
  localparam rob_pkg::word_t INSTR_TAG = 32'h5a00_0000;

  logic clk;
  logic rst;
  logic fetch_req, decode_req, redirect_valid, commit_valid, store_req, flush;
  rob_pkg::word_t     decode_instr;
  rob_pkg::addr_t     redirect_pc, store_addr, flush_pc;
  rob_pkg::reg_idx_t  commit_rd;
  rob_pkg::word_t     commit_value, store_data;
  rob_pkg::mem_len_t  store_len;
  logic               fetch_valid  = 1'b0;
  rob_pkg::addr_t     fetch_pc     = '0;
  rob_pkg::word_t     fetch_instr  = '0;
  logic               decode_valid = 1'b0;
  rob_pkg::op_class_e decode_op    = rob_pkg::OP_ALU;
  rob_pkg::reg_idx_t  decode_rd    = '0;
  rob_pkg::func3_t    decode_func3 = '0;
  rob_pkg::word_t     decode_imm   = '0;
  logic               wb_valid     = 1'b0;
  logic [IDX_W-1:0]   wb_idx       = '0;
  rob_pkg::word_t     wb_result    = '0;
  rob_pkg::addr_t     wb_tar_addr  = '0;
  logic               store_ack    = 1'b0;

  `include "rob_tb_program.svh"

  // model state
  rob_pkg::addr_t   sb[$];
  rob_pkg::addr_t   wb_pc_q[$];
  logic [IDX_W-1:0] wb_idx_q[$];
  logic [IDX_W-1:0] enq_seq;
  rob_pkg::addr_t   next_pc, dec_pc, last_enq_pc;
  rob_pkg::word_t   dec_instr;
  int fetch_cnt, dec_cnt, wb_cnt, ack_cnt, cycles, retired, occ;
  logic store_pending, first_done;
  logic wb_hold, fill_done;

  rob_top #(.IDX_W(IDX_W)) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    void'($urandom(32'h3f39));
    load_program();
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;
  end

  task automatic stop_with_fail(input string line);
    $display("%s", line);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string msg);
    stop_with_fail($sformatf("FAIL %0t: %s", $time, msg));
  endtask

  function automatic rob_pkg::addr_t predicted_next(input rob_pkg::addr_t pc);
    if (prog_op[pc[5:2]] == rob_pkg::OP_JAL || prog_op[pc[5:2]] == rob_pkg::OP_BRANCH)
      return pc + prog_imm[pc[5:2]];
    return pc + 32'd4;
  endfunction

  function automatic logic commits_register(input rob_pkg::addr_t pc);
    return prog_op[pc[5:2]] != rob_pkg::OP_STORE && prog_op[pc[5:2]] != rob_pkg::OP_BRANCH
           && prog_rd[pc[5:2]] != '0;
  endfunction

  function automatic logic raises_flush(input rob_pkg::addr_t pc);
    return prog_op[pc[5:2]] == rob_pkg::OP_JALR ||
           (prog_op[pc[5:2]] == rob_pkg::OP_BRANCH && prog_result[pc[5:2]] == '0);
  endfunction

  function automatic logic is_silent(input rob_pkg::addr_t pc);
    return !commits_register(pc) && !raises_flush(pc) && prog_op[pc[5:2]] != rob_pkg::OP_STORE;
  endfunction

  function automatic rob_pkg::mem_len_t size_code(input rob_pkg::func3_t f3);
    if (f3 == 3'd0) return 2'd0;
    if (f3 == 3'd1) return 2'd1;
    return 2'd3;
  endfunction

  // match one retirement against the oldest non-silent entry in flight
  task automatic check_retirement;
    rob_pkg::addr_t pc;
    rob_pkg::addr_t exp_fpc;
    while (sb.size() > 0 && is_silent(sb[0])) begin
      void'(sb.pop_front());
      retired++;
    end
    if (sb.size() == 0) begin
      stop_with_fail("a retirement appeared with no instruction in flight");
    end else begin
      pc = sb.pop_front();
      retired++;
      exp_fpc = (prog_op[pc[5:2]] == rob_pkg::OP_JALR) ? prog_tar[pc[5:2]] : pc + 32'd4;
      assert (commit_valid == commits_register(pc))
        else report_mismatch($sformatf("commit_valid %0b at pc %0h", commit_valid, pc));
      assert (!commit_valid || (commit_rd == prog_rd[pc[5:2]] &&
                                commit_value == prog_result[pc[5:2]]))
        else report_mismatch($sformatf("commit rd/value wrong at pc %0h", pc));
      assert (store_req == (prog_op[pc[5:2]] == rob_pkg::OP_STORE))
        else report_mismatch($sformatf("store_req %0b at pc %0h", store_req, pc));
      assert (!store_req || (store_addr == prog_tar[pc[5:2]] &&
              store_data == prog_result[pc[5:2]] &&
              store_len == size_code(prog_func3[pc[5:2]])))
        else report_mismatch($sformatf("store fields wrong at pc %0h", pc));
      assert (flush == raises_flush(pc))
        else report_mismatch($sformatf("flush %0b at pc %0h", flush, pc));
      assert (!flush || flush_pc == exp_fpc)
        else report_mismatch($sformatf("flush_pc %0h, expected %0h", flush_pc, exp_fpc));
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      sb.delete();
      wb_pc_q.delete();
      wb_idx_q.delete();
      enq_seq = '0;
      next_pc = '0;
      fetch_cnt = -1;
      dec_cnt = -1;
      wb_cnt = -1;
      ack_cnt = -1;
      cycles = 0;
      retired = 0;
      wb_hold = 1'b0;
      fill_done = 1'b0;
      occ <= 0;
    end else begin
      cycles++;
      if (commit_valid || store_req || flush) check_retirement();
      if (redirect_valid) begin
        assert (redirect_pc == predicted_next(last_enq_pc))
          else report_mismatch($sformatf("redirect_pc %0h after pc %0h",
                                         redirect_pc, last_enq_pc));
        if (!flush) next_pc = redirect_pc;
      end
      if (decode_valid && !flush) begin
        sb.push_back(dec_pc);
        wb_pc_q.push_back(dec_pc);
        wb_idx_q.push_back(enq_seq);
        enq_seq = enq_seq + 1'b1;
        last_enq_pc = dec_pc;
      end
      if (flush) begin
        // outside units drop everything in flight
        next_pc = flush_pc;
        sb.delete();
        wb_pc_q.delete();
        wb_idx_q.delete();
        enq_seq = '0;
        fetch_cnt = -1;
        dec_cnt = -1;
        wb_cnt = -1;
      end else begin
        if (fetch_req) fetch_cnt = int'($urandom % 4);
        if (decode_req) begin
          dec_cnt = int'($urandom % 4);
          dec_instr = decode_instr;
        end
      end
      if (store_req) ack_cnt = int'($urandom % 4);
      // hold write-backs once so the queue fills up to its limit
      if (retired >= FILL_AT && !fill_done) wb_hold = 1'b1;
      if (wb_hold && wb_idx_q.size() >= DEPTH - 1) begin
        wb_hold = 1'b0;
        fill_done = 1'b1;
      end
      if (wb_cnt < 0 && wb_idx_q.size() > 0 && !wb_hold) wb_cnt = int'($urandom % 4);
      occ <= sb.size();
    end
    #1;
    fetch_valid = 1'b0;
    decode_valid = 1'b0;
    wb_valid = 1'b0;
    store_ack = 1'b0;
    if (fetch_cnt == 0) begin
      fetch_valid = 1'b1;
      fetch_pc = next_pc;
      fetch_instr = INSTR_TAG | next_pc;
    end
    if (dec_cnt == 0) begin
      dec_pc = dec_instr & 32'h00ff_ffff;
      decode_valid = 1'b1;
      decode_op = prog_op[dec_pc[5:2]];
      decode_rd = prog_rd[dec_pc[5:2]];
      decode_func3 = prog_func3[dec_pc[5:2]];
      decode_imm = prog_imm[dec_pc[5:2]];
    end
    if (wb_cnt == 0) begin
      wb_valid = 1'b1;
      wb_idx = wb_idx_q.pop_front();
      wb_result = prog_result[wb_pc_q[0][5:2]];
      wb_tar_addr = prog_tar[wb_pc_q[0][5:2]];
      void'(wb_pc_q.pop_front());
    end
    if (ack_cnt == 0) store_ack = 1'b1;
    if (fetch_cnt >= 0) fetch_cnt--;
    if (dec_cnt >= 0) dec_cnt--;
    if (wb_cnt >= 0) wb_cnt--;
    if (ack_cnt >= 0) ack_cnt--;
  end

  initial begin
    while (retired < N_RETIRE && cycles <= TIMEOUT) begin
      @(posedge clk);
      #2;
    end
    if (retired >= N_RETIRE) begin
      $display(">>> PASS");
      $finish;
    end else begin
      stop_with_fail("timeout: the program did not retire in time");
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      store_pending <= 1'b0;
      first_done <= 1'b0;
    end else begin
      if (fetch_valid) first_done <= 1'b1;
      if (store_req) store_pending <= 1'b1;
      else if (store_ack) store_pending <= 1'b0;
    end
  end

  a_quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
    !first_done |-> !(decode_req || redirect_valid || commit_valid || store_req || flush))
    else report_mismatch("output active before the first fetch completed");

  a_store_blocks: assert property (@(posedge clk) disable iff (rst)
    store_pending |-> !(commit_valid || store_req || flush))
    else report_mismatch("retirement while a store awaits its ack");

  a_no_rd_zero: assert property (@(posedge clk) disable iff (rst)
    commit_valid |-> commit_rd != '0)
    else report_mismatch("commit to register zero");

  a_fetch_room: assert property (@(posedge clk) disable iff (rst)
    fetch_req |-> occ + 1 < DEPTH)
    else report_mismatch($sformatf("fetch_req with %0d entries in flight", occ));

endmodule
